// ==== rf_pkg.sv ====
// Register file geometry and the write-port bundle used by both register file write ports
package rf_pkg;

  ////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////

  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  // Two read ports, one per source operand
  localparam int NUM_RD_PORTS = 2;

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Same layout for the forward port and the WB port
  typedef struct packed {
    logic              we;
    logic [REG_AW-1:0] waddr;
    logic [31:0]       wdata;
  } rf_wr_t;

endpackage

// ==== ex_pkg.sv ====
// Opcodes, ALU operations and decoded control bundle shared by decoder, ALU and execute stage
package ex_pkg;

  // Register address width comes from the register file package
  import rf_pkg::*;

  // Instruction word fields
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 28;
  localparam int RD_MSB  = 27;
  localparam int RD_LSB  = 23;
  localparam int RS1_MSB = 22;
  localparam int RS1_LSB = 18;
  localparam int RS2_MSB = 17;
  localparam int RS2_LSB = 13;
  localparam int IMM_MSB = 12;
  localparam int IMM_LSB = 0;

  // Iterative multiplier, one byte of op_b per step
  localparam int MULT_STEPS = 4;
  localparam int MULT_CNT_W = $clog2(MULT_STEPS);

  // Major opcode, bits 31..28
  typedef enum logic [3:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
    OP_SLT, OP_SLTU, OP_ADDI, OP_MUL, OP_MULHU, OP_BEQ, OP_BNE, OP_BLT
  } op_e;

  // ALU function select, branch compares at the end
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LTS
  } alu_op_e;

  // Decoded instruction as seen by the execute stage
  typedef struct packed {
    logic              alu_en;
    alu_op_e           alu_op;
    logic              mult_en;
    logic              mult_high;
    logic              branch;
    logic              rd_we;
    logic [REG_AW-1:0] rd;
    logic [31:0]       op_a;
    logic [31:0]       op_b;
    logic [31:0]       imm;
  } ex_ctrl_t;

endpackage

// ==== ex_decoder.sv ====
// Instruction decoder, drives register read addresses and builds the execute control bundle
`timescale 1ns/1ps

module ex_decoder import ex_pkg::*, rf_pkg::*; (
  input  logic              instr_valid_i,
  input  logic [31:0]       instr_i,
  output logic [REG_AW-1:0] raddr_a_o,
  output logic [REG_AW-1:0] raddr_b_o,
  input  logic [31:0]       rdata_a_i,
  input  logic [31:0]       rdata_b_i,
  output ex_ctrl_t          ctrl_o
);

  op_e               opcode;
  logic [REG_AW-1:0] rd;
  logic [31:0]       imm_sext;
  logic              is_mult;
  logic              is_branch;
  alu_op_e           alu_op;

  // Field extraction
  assign opcode    = op_e'(instr_i[OPC_MSB:OPC_LSB]);
  assign rd        = instr_i[RD_MSB:RD_LSB];
  assign raddr_a_o = instr_i[RS1_MSB:RS1_LSB];
  assign raddr_b_o = instr_i[RS2_MSB:RS2_LSB];

  // 13-bit immediate, sign extended to 32
  assign imm_sext = {{(31 - IMM_MSB){instr_i[IMM_MSB]}}, instr_i[IMM_MSB:IMM_LSB]};

  // Instruction classes
  assign is_mult   = (opcode == OP_MUL) || (opcode == OP_MULHU);
  assign is_branch = (opcode == OP_BEQ) || (opcode == OP_BNE) || (opcode == OP_BLT);

  // Opcode to ALU function
  always_comb begin
    case (opcode)
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_XOR:  alu_op = ALU_XOR;
      OP_SLL:  alu_op = ALU_SLL;
      OP_SRL:  alu_op = ALU_SRL;
      OP_SRA:  alu_op = ALU_SRA;
      OP_SLT:  alu_op = ALU_SLT;
      OP_SLTU: alu_op = ALU_SLTU;
      OP_BEQ:  alu_op = ALU_EQ;
      OP_BNE:  alu_op = ALU_NE;
      OP_BLT:  alu_op = ALU_LTS;
      // ADD, ADDI; ALU idles on multiplies
      default: alu_op = ALU_ADD;
    endcase
  end

  // Control bundle, all enables gated by the valid strobe
  always_comb begin
    ctrl_o           = '0;
    ctrl_o.alu_op    = alu_op;
    ctrl_o.alu_en    = instr_valid_i & ~is_mult;
    ctrl_o.mult_en   = instr_valid_i & is_mult;
    ctrl_o.mult_high = (opcode == OP_MULHU);
    ctrl_o.branch    = instr_valid_i & is_branch;
    // No write for branches or for x0
    ctrl_o.rd_we     = instr_valid_i & ~is_branch & (rd != '0);
    ctrl_o.rd        = rd;
    ctrl_o.op_a      = rdata_a_i;
    // ADDI takes the immediate in place of rs2
    ctrl_o.op_b      = (opcode == OP_ADDI) ? imm_sext : rdata_b_i;
    ctrl_o.imm       = imm_sext;
  end

endmodule

// ==== ex_alu.sv ====
// Single-cycle ALU with add/sub, logic, shifts, set-less-than and branch compares
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  alu_op_e     operator_i,
  input  logic [31:0] operand_a_i,
  input  logic [31:0] operand_b_i,
  output logic [31:0] result_o,
  output logic        cmp_result_o
);

  logic        sub;
  logic [31:0] adder_b;
  logic [31:0] adder_result;
  logic [4:0]  shamt;
  logic [31:0] shift_left;
  logic [31:0] shift_right_log;
  logic [31:0] shift_right_arith;
  logic        is_equal;
  logic        less_signed;
  logic        less_unsigned;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  // Subtract as a + ~b + 1
  assign sub          = (operator_i == ALU_SUB);
  assign adder_b      = sub ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_b + {31'b0, sub};

  ////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////

  // Only the low five bits of b count
  assign shamt             = operand_b_i[4:0];
  assign shift_left        = operand_a_i << shamt;
  assign shift_right_log   = operand_a_i >> shamt;
  assign shift_right_arith = $unsigned($signed(operand_a_i) >>> shamt);

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  assign is_equal      = (operand_a_i == operand_b_i);
  assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign less_unsigned = (operand_a_i < operand_b_i);

  // Branch decision, low for non-branch operations
  always_comb begin
    case (operator_i)
      ALU_EQ:  cmp_result_o = is_equal;
      ALU_NE:  cmp_result_o = ~is_equal;
      ALU_LTS: cmp_result_o = less_signed;
      default: cmp_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (operator_i)
      ALU_ADD,
      ALU_SUB:  result_o = adder_result;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = shift_left;
      ALU_SRL:  result_o = shift_right_log;
      ALU_SRA:  result_o = shift_right_arith;
      ALU_SLT:  result_o = {31'b0, less_signed};
      ALU_SLTU: result_o = {31'b0, less_unsigned};
      // Compares report through cmp_result_o
      default:  result_o = {31'b0, cmp_result_o};
    endcase
  end

endmodule

// ==== ex_mult.sv ====
// Iterative unsigned multiplier, one byte of op_b per cycle, low or high product word out
`timescale 1ns/1ps

module ex_mult import ex_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable_i,
  input  logic        high_i,
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  input  logic        ex_ready_i,
  output logic [31:0] result_o,
  output logic        ready_o
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } mult_state_e;

  mult_state_e           state_q;
  logic [MULT_CNT_W-1:0] cnt_q;
  logic [4:0]            byte_sel;
  logic [7:0]            op_b_byte;
  logic [63:0]           partial;
  logic [63:0]           acc_q;
  logic                  last_step;

  // Byte of op_b for this step, placed at its weight
  assign byte_sel  = {cnt_q, 3'b000};
  assign op_b_byte = op_b_i[byte_sel +: 8];
  assign partial   = ({32'b0, op_a_i} * {56'b0, op_b_byte}) << byte_sel;
  assign last_step = (cnt_q == MULT_CNT_W'(MULT_STEPS - 1));

  ////////////////////////////////////////
  // Step counter FSM
  ////////////////////////////////////////

  // IDLE takes step 0 in the issue cycle, RUN the remaining three
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (enable_i) begin
            state_q <= RUN;
            cnt_q   <= cnt_q + 1'b1;
          end
        end
        RUN: begin
          // Counter wraps to zero on the last step
          cnt_q <= cnt_q + 1'b1;
          if (last_step) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          // Hold the product until the stage accepts it
          if (ex_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Accumulator, first step overwrites
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      acc_q <= partial;
    end else if (state_q == RUN) begin
      acc_q <= acc_q + partial;
    end
  end

  assign ready_o  = (state_q == DONE);
  assign result_o = high_i ? acc_q[63:32] : acc_q[31:0];

  // Operands come straight from the register file and must stay put
  assert property (@(posedge clk) disable iff (!rst_n) (state_q == RUN) |-> enable_i)
    else $error("ex_mult: enable dropped while multiplying");

endmodule

// ==== ex_stage.sv ====
// Execute stage, ALU on the forward port and multiplier through the EX/WB register
`timescale 1ns/1ps

module ex_stage import ex_pkg::*, rf_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  ex_ctrl_t    ctrl_i,
  output logic        ex_ready_o,
  output rf_wr_t      alu_wr_o,
  output rf_wr_t      wb_wr_o,
  output logic        branch_taken_o,
  output logic [31:0] jump_target_o
);

  logic [31:0]       alu_result;
  logic              alu_cmp_result;
  logic [31:0]       mult_result;
  logic              mult_ready;
  logic              mult_accept;
  logic              wb_collide;
  logic              wb_we_q;
  logic [REG_AW-1:0] wb_waddr_q;
  logic [31:0]       wb_wdata_q;

  ////////////////////////////////////////
  // Units
  ////////////////////////////////////////

  ex_alu alu_i (
    .operator_i   ( ctrl_i.alu_op  ),
    .operand_a_i  ( ctrl_i.op_a    ),
    .operand_b_i  ( ctrl_i.op_b    ),
    .result_o     ( alu_result     ),
    .cmp_result_o ( alu_cmp_result )
  );

  ex_mult mult_i (
    .clk        ( clk              ),
    .rst_n      ( rst_n            ),
    .enable_i   ( ctrl_i.mult_en   ),
    .high_i     ( ctrl_i.mult_high ),
    .op_a_i     ( ctrl_i.op_a      ),
    .op_b_i     ( ctrl_i.op_b      ),
    .ex_ready_i ( ex_ready_o       ),
    .result_o   ( mult_result      ),
    .ready_o    ( mult_ready       )
  );

  // ALU write to the register the WB port is writing this cycle
  // Younger write waits one cycle so the two ports never meet
  assign wb_collide = ctrl_i.alu_en & ctrl_i.rd_we & wb_we_q & (ctrl_i.rd == wb_waddr_q);

  // Multiplier holds the stage, otherwise only a collision does
  assign ex_ready_o = ctrl_i.mult_en ? mult_ready : ~wb_collide;

  // Forward port, written at the acceptance edge
  always_comb begin
    alu_wr_o.we    = ctrl_i.alu_en & ctrl_i.rd_we & ~wb_collide;
    alu_wr_o.waddr = ctrl_i.rd;
    alu_wr_o.wdata = alu_result;
  end

  // Branch outcome, target is the immediate itself
  assign branch_taken_o = ctrl_i.branch & alu_cmp_result;
  assign jump_target_o  = ctrl_i.imm;

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  assign mult_accept = ctrl_i.mult_en & mult_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else begin
      wb_we_q <= mult_accept & ctrl_i.rd_we;
    end
  end

  // Payload only moves on a multiplier hand-off
  always_ff @(posedge clk) begin
    if (mult_accept) begin
      wb_waddr_q <= ctrl_i.rd;
      wb_wdata_q <= mult_result;
    end
  end

  always_comb begin
    wb_wr_o.we    = wb_we_q;
    wb_wr_o.waddr = wb_waddr_q;
    wb_wr_o.wdata = wb_wdata_q;
  end

  // Two write ports never target one register in the same cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    !(alu_wr_o.we && wb_wr_o.we && (alu_wr_o.waddr == wb_wr_o.waddr)))
    else $error("ex_stage: forward and WB ports write the same register");

  // A taken branch comes from a decoded branch and writes nothing
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_o |-> (ctrl_i.branch && !alu_wr_o.we))
    else $error("ex_stage: taken branch without a branch instruction");

endmodule

// ==== wb_regfile.sv ====
// 32x32 register file with forward and WB write ports, two read ports and WB bypass
`timescale 1ns/1ps

module wb_regfile import rf_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [REG_AW-1:0] raddr_a_i,
  input  logic [REG_AW-1:0] raddr_b_i,
  output logic [31:0]       rdata_a_o,
  output logic [31:0]       rdata_b_o,
  input  rf_wr_t            alu_wr_i,
  input  rf_wr_t            wb_wr_i
);

  logic [31:0]       regs_q [NUM_REGS];
  logic [REG_AW-1:0] raddr  [NUM_RD_PORTS];
  logic [31:0]       rdata  [NUM_RD_PORTS];

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  // Entry 0 is never written and stays zero from reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (wb_wr_i.we && (wb_wr_i.waddr != '0)) begin
        regs_q[wb_wr_i.waddr] <= wb_wr_i.wdata;
      end
      // Forward port last, it carries the younger instruction
      if (alu_wr_i.we && (alu_wr_i.waddr != '0)) begin
        regs_q[alu_wr_i.waddr] <= alu_wr_i.wdata;
      end
    end
  end

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  assign raddr[0]  = raddr_a_i;
  assign raddr[1]  = raddr_b_i;
  assign rdata_a_o = rdata[0];
  assign rdata_b_o = rdata[1];

  // WB data goes straight to readers in its write cycle
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      if (raddr[p] == '0) begin
        rdata[p] = '0;
      end else if (wb_wr_i.we && (wb_wr_i.waddr == raddr[p])) begin
        rdata[p] = wb_wr_i.wdata;
      end else begin
        rdata[p] = regs_q[raddr[p]];
      end
    end
  end

endmodule

// ==== ex_top.sv ====
// Execute subsystem top, connects decoder, register file and execute stage
`timescale 1ns/1ps

module ex_top import ex_pkg::*, rf_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  output logic        ex_ready_o,
  output rf_wr_t      alu_wr_o,
  output rf_wr_t      wb_wr_o,
  output logic        branch_taken_o,
  output logic [31:0] jump_target_o
);

  logic [REG_AW-1:0] raddr_a;
  logic [REG_AW-1:0] raddr_b;
  logic [31:0]       rdata_a;
  logic [31:0]       rdata_b;
  ex_ctrl_t          ex_ctrl;

  // Decode reads operands in the issue cycle
  ex_decoder decoder_i (
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .raddr_a_o     ( raddr_a       ),
    .raddr_b_o     ( raddr_b       ),
    .rdata_a_i     ( rdata_a       ),
    .rdata_b_i     ( rdata_b       ),
    .ctrl_o        ( ex_ctrl       )
  );

  // Both write ports loop back from the execute stage
  wb_regfile regfile_i (
    .clk       ( clk      ),
    .rst_n     ( rst_n    ),
    .raddr_a_i ( raddr_a  ),
    .raddr_b_i ( raddr_b  ),
    .rdata_a_o ( rdata_a  ),
    .rdata_b_o ( rdata_b  ),
    .alu_wr_i  ( alu_wr_o ),
    .wb_wr_i   ( wb_wr_o  )
  );

  ex_stage ex_stage_i (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .ctrl_i         ( ex_ctrl        ),
    .ex_ready_o     ( ex_ready_o     ),
    .alu_wr_o       ( alu_wr_o       ),
    .wb_wr_o        ( wb_wr_o        ),
    .branch_taken_o ( branch_taken_o ),
    .jump_target_o  ( jump_target_o  )
  );

endmodule

// ==== tb_ex_top.sv ====
// Random-stimulus testbench for ex_top, checks every cycle against an ISA-level model
`timescale 1ns/1ps

module tb_ex_top import ex_pkg::*, rf_pkg::*; ();

  localparam int NUM_INSTR      = 2000;
  localparam int RESET_CYCLES   = 4;
  localparam int SEED           = 57848;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 6 + RESET_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        instr_valid_i;
  logic [31:0] instr_i;
  logic        ex_ready_o;
  rf_wr_t      alu_wr_o;
  rf_wr_t      wb_wr_o;
  logic        branch_taken_o;
  logic [31:0] jump_target_o;

  // Architectural model and the instruction on the bus
  logic [31:0]       model_regs [NUM_REGS];
  logic              cur_valid;
  logic [31:0]       cur_instr;
  logic              cur_is_mult;
  // Result of the instruction accepted this cycle
  logic              accepted;
  logic              acc_write;
  logic              acc_is_mult;
  logic [REG_AW-1:0] acc_rd;
  logic [31:0]       acc_data;
  // Expected WB port, one cycle after a multiply is accepted
  rf_wr_t            wb_exp;
  int                mult_cyc;
  int                issued;
  int                retired;
  int                cycle_cnt;
  // Event counters
  int                n_alu_wr;
  int                n_mult;
  int                n_taken;
  int                n_bypass;
  int                n_stall;

  ex_top dut_i (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_i        ( instr_i        ),
    .ex_ready_o     ( ex_ready_o     ),
    .alu_wr_o       ( alu_wr_o       ),
    .wb_wr_o        ( wb_wr_o        ),
    .branch_taken_o ( branch_taken_o ),
    .jump_target_o  ( jump_target_o  )
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Run length guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end_with_failure();
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [31:0] sext13(logic [12:0] imm);
    return {{19{imm[12]}}, imm};
  endfunction

  function automatic logic [31:0] alu_model(op_e opc, logic [31:0] a, logic [31:0] b,
                                            logic [31:0] imm);
    logic [31:0] res;
    case (opc)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SLL:  res = a << b[4:0];
      OP_SRL:  res = a >> b[4:0];
      OP_SRA:  res = $unsigned($signed(a) >>> b[4:0]);
      OP_SLT:  res = {31'b0, ($signed(a) < $signed(b))};
      OP_SLTU: res = {31'b0, (a < b)};
      OP_ADDI: res = a + imm;
      default: res = '0;
    endcase
    return res;
  endfunction

  function automatic logic branch_model(op_e opc, logic [31:0] a, logic [31:0] b);
    case (opc)
      OP_BEQ:  return a == b;
      OP_BNE:  return a != b;
      OP_BLT:  return $signed(a) < $signed(b);
      default: return 1'b0;
    endcase
  endfunction

  // Full unsigned product, low or high word
  function automatic logic [31:0] mult_model(logic high, logic [31:0] a, logic [31:0] b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    return high ? prod[63:32] : prod[31:0];
  endfunction

  // Mostly a small register set so operands depend on recent results
  function automatic logic [REG_AW-1:0] pick_reg();
    if ($urandom_range(0, 3) == 0) begin
      return REG_AW'($urandom_range(0, NUM_REGS - 1));
    end
    return REG_AW'($urandom_range(0, 7));
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] instr;
    instr                  = $urandom;
    instr[OPC_MSB:OPC_LSB] = 4'($urandom_range(0, 15));
    instr[RD_MSB:RD_LSB]   = pick_reg();
    instr[RS1_MSB:RS1_LSB] = pick_reg();
    instr[RS2_MSB:RS2_LSB] = pick_reg();
    return instr;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic end_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped on failure");
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t ex_ready_o got %0b expected %0b", $time, got, exp);
      end_with_failure();
    end
  endtask

  // Address and data only count when a write is expected
  task automatic check_wr(input string name, input rf_wr_t got, input rf_wr_t exp);
    if (got.we !== exp.we) begin
      $display("[ERROR] t=%0t %s.we got %0b expected %0b", $time, name, got.we, exp.we);
      end_with_failure();
    end else if (exp.we && (got.waddr !== exp.waddr)) begin
      $display("[ERROR] t=%0t %s.waddr got %0d expected %0d", $time, name, got.waddr,
               exp.waddr);
      end_with_failure();
    end else if (exp.we && (got.wdata !== exp.wdata)) begin
      $display("[ERROR] t=%0t %s.wdata got %h expected %h", $time, name, got.wdata,
               exp.wdata);
      end_with_failure();
    end
  endtask

  task automatic check_branch(input logic got_taken, input logic [31:0] got_target,
                              input logic exp_taken, input logic [31:0] exp_target,
                              input logic is_branch);
    if (got_taken !== exp_taken) begin
      $display("[ERROR] t=%0t branch_taken_o got %0b expected %0b", $time, got_taken,
               exp_taken);
      end_with_failure();
    end else if (is_branch && (got_target !== exp_target)) begin
      $display("[ERROR] t=%0t jump_target_o got %h expected %h", $time, got_target,
               exp_target);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // Per-cycle steps
  ////////////////////////////////////////

  // Expected outputs for the instruction on the bus, sampled mid-cycle
  task automatic check_cycle();
    op_e               opc;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       imm;
    logic              is_branch;
    logic              writes_alu;
    logic              collide;
    logic              exp_ready;
    logic              exp_taken;
    rf_wr_t            exp_alu;
    opc         = op_e'(cur_instr[OPC_MSB:OPC_LSB]);
    rd          = cur_instr[RD_MSB:RD_LSB];
    rs1         = cur_instr[RS1_MSB:RS1_LSB];
    rs2         = cur_instr[RS2_MSB:RS2_LSB];
    a           = model_regs[rs1];
    b           = model_regs[rs2];
    imm         = sext13(cur_instr[IMM_MSB:IMM_LSB]);
    cur_is_mult = cur_valid && ((opc == OP_MUL) || (opc == OP_MULHU));
    is_branch   = cur_valid && ((opc == OP_BEQ) || (opc == OP_BNE) || (opc == OP_BLT));
    writes_alu  = cur_valid && !cur_is_mult && !is_branch && (rd != '0);
    // ALU write to the register on the WB port waits a cycle
    collide     = writes_alu && wb_exp.we && (wb_exp.waddr == rd);
    if (!cur_valid) begin
      exp_ready = 1'b1;
    end else if (cur_is_mult) begin
      exp_ready = (mult_cyc == MULT_STEPS);
    end else begin
      exp_ready = !collide;
    end
    exp_alu.we    = writes_alu && !collide;
    exp_alu.waddr = rd;
    exp_alu.wdata = alu_model(opc, a, b, imm);
    exp_taken     = is_branch && branch_model(opc, a, b);
    check_ready(ex_ready_o, exp_ready);
    check_wr("alu_wr_o", alu_wr_o, exp_alu);
    check_wr("wb_wr_o", wb_wr_o, wb_exp);
    check_branch(branch_taken_o, jump_target_o, exp_taken, imm, is_branch);
    accepted    = cur_valid && exp_ready;
    acc_is_mult = cur_is_mult;
    acc_rd      = rd;
    acc_write   = accepted && (rd != '0) && !is_branch;
    acc_data    = cur_is_mult ? mult_model(opc == OP_MULHU, a, b) : exp_alu.wdata;
    if (accepted && exp_alu.we) n_alu_wr++;
    if (accepted && cur_is_mult) n_mult++;
    if (exp_taken) n_taken++;
    if (collide) n_stall++;
    // Operand taken from the WB port in its write cycle
    if (accepted && wb_exp.we &&
        ((rs1 == wb_exp.waddr) || ((opc != OP_ADDI) && (rs2 == wb_exp.waddr)))) begin
      n_bypass++;
    end
  endtask

  // Commit at the rising edge
  task automatic advance_model();
    wb_exp = '0;
    if (accepted) begin
      if (acc_write) model_regs[acc_rd] = acc_data;
      if (acc_write && acc_is_mult) begin
        wb_exp.we    = 1'b1;
        wb_exp.waddr = acc_rd;
        wb_exp.wdata = acc_data;
      end
      retired++;
      mult_cyc = 0;
    end else if (cur_is_mult) begin
      mult_cyc++;
    end
  endtask

  // New instruction only after acceptance, about a quarter of slots idle
  task automatic drive_next();
    logic chain;
    chain = accepted && acc_is_mult && acc_write && ($urandom_range(0, 1) == 1);
    if (accepted || !cur_valid) begin
      if ((issued >= NUM_INSTR) || ($urandom_range(0, 3) == 0)) begin
        cur_valid = 1'b0;
      end else begin
        cur_valid = 1'b1;
        cur_instr = random_instr();
        // Read the fresh product right away
        if (chain) cur_instr[RS1_MSB:RS1_LSB] = acc_rd;
        issued++;
      end
    end
    instr_valid_i <= cur_valid;
    instr_i       <= cur_instr;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    void'($urandom(SEED));
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    cur_valid   = 1'b0;
    cur_instr   = '0;
    cur_is_mult = 1'b0;
    accepted    = 1'b0;
    acc_write   = 1'b0;
    acc_is_mult = 1'b0;
    acc_rd      = '0;
    acc_data    = '0;
    wb_exp      = '0;
    mult_cyc    = 0;
    issued      = 0;
    retired     = 0;
    cycle_cnt   = 0;
    n_alu_wr    = 0;
    n_mult      = 0;
    n_taken     = 0;
    n_bypass    = 0;
    n_stall     = 0;
    // Quiet outputs while reset is held
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_cycle();
    @(posedge clk);
    rst_n <= 1'b1;
    // First pass checks the idle state out of reset
    while ((retired < NUM_INSTR) || wb_exp.we) begin
      @(negedge clk);
      check_cycle();
      @(posedge clk);
      advance_model();
      drive_next();
    end
    $display("Retired %0d: ALU writes %0d, multiplies %0d, taken branches %0d", retired,
             n_alu_wr, n_mult, n_taken);
    $display("WB bypass reads %0d, port collision stalls %0d", n_bypass, n_stall);
    if ((n_alu_wr > 0) && (n_mult > 0) && (n_taken > 0) && (n_bypass > 0)) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("Stimulus missed an ALU write, a multiply, a taken branch or a bypass read");
      end_with_failure();
    end
  end

endmodule

// ==== flist.f ====
rf_pkg.sv
ex_pkg.sv
ex_decoder.sv
ex_alu.sv
ex_mult.sv
ex_stage.sv
wb_regfile.sv
ex_top.sv
tb_ex_top.sv
